// ==== hw/execPkg.sv ====
// Shared types for the integer execute stage
// XLEN is fixed at 32; there is no RV64 or W-type support
// Opcodes arrive already decoded, so no funct3/funct7 fields exist
// Zbs and Zbc ops are only legal when their feature bit is set

package execPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN    = 32;            // Operand width
  localparam int SHAMT_W = $clog2(XLEN);  // Shift amount bits, 5

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ADD    = 5'd0,
    SUB    = 5'd1,
    SLL    = 5'd2,
    SRL    = 5'd3,
    SRA    = 5'd4,
    SLT    = 5'd5,
    SLTU   = 5'd6,
    XOR    = 5'd7,
    OR     = 5'd8,
    AND    = 5'd9,
    BSET   = 5'd10,  // Zbs group starts here
    BCLR   = 5'd11,
    BINV   = 5'd12,
    BEXT   = 5'd13,
    CLMUL  = 5'd14,  // Zbc group
    CLMULH = 5'd15,
    CLMULR = 5'd16
  } aluOpE;

  ////////////////////////////////////////////////////////////////////////////
  // Request, response and feature bundles
  ////////////////////////////////////////////////////////////////////////////

  // 73 bits, op in the top bits
  typedef struct packed {
    aluOpE           op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [3:0]      tag;  // Opaque label, returned as is
  } execReqT;

  // 37 bits
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            illegal;  // Op from a disabled extension
    logic [3:0]      tag;
  } execRespT;

  // Run-time extension enables, misa style
  typedef struct packed {
    logic zbsEn;
    logic zbcEn;
  } featureT;

endpackage

// ==== hw/featureRegs.sv ====
// Extension enable register beside the execute stage
// Both Zbs and Zbc come out of reset enabled
// A cfgWe pulse loads cfgData at that clock edge, so the
// next request already sees the new enables

`timescale 1ns/1ps

module featureRegs import execPkg::*; (
  input  logic    clk,
  input  logic    rst,      // Sync, active high
  input  logic    cfgWe,    // One-cycle write strobe
  input  featureT cfgData,  // New enable bits
  output featureT features  // Current enables to the stage
);

  featureT featureQ;

  // Enable register
  always_ff @(posedge clk) begin
    if (rst) begin
      featureQ.zbsEn <= 1'b1;  // All extensions on after reset
      featureQ.zbcEn <= 1'b1;
    end else if (cfgWe) begin
      featureQ <= cfgData;     // Full replace, no per-bit mask
    end
  end

  // Straight from the flops, no bypass of cfgData
  assign features = featureQ;

endmodule

// ==== hw/shifter.sv ====
// Barrel shifter for sll, srl and sra
// Only right shifts exist in hardware; left shifts reverse the
// operand before and after the barrel
// arith is only meaningful with right set; the alu never combines
// arith with a left shift

`timescale 1ns/1ps

module shifter import execPkg::*; (
  input  logic [XLEN-1:0]    value,  // Operand to shift
  input  logic [SHAMT_W-1:0] amt,    // Shift amount
  input  logic               right,  // 1 right, 0 left
  input  logic               arith,  // Sign fill
  output logic [XLEN-1:0]    y
);

  logic [XLEN-1:0] revIn;                // Operand after optional reversal
  logic [XLEN-1:0] stageVal [SHAMT_W+1]; // Barrel stages, 0 is the input
  logic            fill;                 // Bit shifted in from the top

  // Reverse for left shifts
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revIn[i] = right ? value[i] : value[XLEN-1-i];
    end
  end

  assign fill        = arith & value[XLEN-1];  // Zero unless arithmetic
  assign stageVal[0] = revIn;

  // One stage per amount bit, distance doubles each time
  for (genvar s = 0; s < SHAMT_W; s++) begin : gStage
    assign stageVal[s+1] = amt[s] ? {{(1 << s){fill}}, stageVal[s][XLEN-1:(1 << s)]}
                                  : stageVal[s];
  end

  // Undo the reversal on the way out
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      y[i] = right ? stageVal[SHAMT_W][i] : stageVal[SHAMT_W][XLEN-1-i];
    end
  end

endmodule

// ==== hw/clmulUnit.sv ====
// Carry-less multiplier for the Zbc ops
// Purely combinational, one XOR-accumulate row per bit of b
// low is clmul, high is clmulh, rev is clmulr
// The full product is 2*XLEN-1 bits wide; bit 63 is always zero

`timescale 1ns/1ps

module clmulUnit import execPkg::*; (
  input  logic [XLEN-1:0] a,     // Multiplicand
  input  logic [XLEN-1:0] b,     // Multiplier, selects the rows
  output logic [XLEN-1:0] low,   // Product bits 31..0
  output logic [XLEN-1:0] high,  // Product bits 63..32
  output logic [XLEN-1:0] rev    // Product bits 62..31
);

  logic [2*XLEN-2:0] prod;   // 63-bit XOR product
  logic [2*XLEN-2:0] aWide;  // a zero extended to product width

  assign aWide = {{(XLEN-1){1'b0}}, a};

  ////////////////////////////////////////////////////////////////////////////
  // XOR accumulation
  ////////////////////////////////////////////////////////////////////////////

  // Each set bit of b adds a shifted copy of a, no carries
  always_comb begin
    prod = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (b[i]) begin
        prod = prod ^ (aWide << i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result windows
  ////////////////////////////////////////////////////////////////////////////

  assign low  = prod[XLEN-1:0];
  assign high = {1'b0, prod[2*XLEN-2:XLEN]};  // Top bit has no source
  // Same as the reversed-operand product, taken one bit lower
  assign rev  = prod[2*XLEN-2:XLEN-1];

endmodule

// ==== hw/alu.sv ====
// Integer ALU for RV32I register ops plus Zbs and Zbc
// Combinational, no legality check here; the execute stage
// handles disabled extensions
// Shift amount and bit index both come from b[4:0]
// sum is the raw adder output, also valid for add and sub

`timescale 1ns/1ps

module alu import execPkg::*; (
  input  aluOpE           op,      // Decoded operation
  input  logic [XLEN-1:0] a,       // rs1 operand
  input  logic [XLEN-1:0] b,       // rs2 operand
  output logic [XLEN-1:0] result,  // Selected result
  output logic [XLEN-1:0] sum      // Adder output
);

  logic            subOp;       // Subtract for sub, slt, sltu
  logic            shiftRight;  // srl, sra
  logic            shiftArith;  // sra only
  logic            maskSel;     // Single-bit ops use the decoded mask
  logic            invB;        // Invert second operand
  logic [XLEN-1:0] mask;        // One-hot from b[4:0]
  logic [XLEN-1:0] condB;       // b or mask
  logic [XLEN-1:0] condInvB;    // condB, optionally inverted
  logic            carry;
  logic            lt;
  logic            ltu;
  logic [XLEN-1:0] shiftY;
  logic [XLEN-1:0] clLow;
  logic [XLEN-1:0] clHigh;
  logic [XLEN-1:0] clRev;

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  assign subOp      = (op == SUB) | (op == SLT) | (op == SLTU);
  assign shiftRight = (op == SRL) | (op == SRA);
  assign shiftArith = (op == SRA);
  assign maskSel    = op inside {BSET, BCLR, BINV, BEXT};
  assign invB       = subOp | (op == BCLR);  // bclr reuses the inverted path

  // Bit-index decoder
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      mask[i] = (b[SHAMT_W-1:0] == i[SHAMT_W-1:0]);
    end
  end

  assign condB    = maskSel ? mask : b;
  assign condInvB = invB ? ~condB : condB;

  ////////////////////////////////////////////////////////////////////////////
  // Adder and compares
  ////////////////////////////////////////////////////////////////////////////

  // Shared adder, carry in completes the two's complement
  assign {carry, sum} = a + condInvB + {{(XLEN-1){1'b0}}, subOp};

  // Signed less-than from the sign bits and the sign of a - b
  assign lt  = (a[XLEN-1] & ~b[XLEN-1]) | (a[XLEN-1] & sum[XLEN-1])
             | (~b[XLEN-1] & sum[XLEN-1]);
  assign ltu = ~carry;  // Borrow out

  // Units
  shifter shifter_i (
    .value (a),
    .amt   (b[SHAMT_W-1:0]),
    .right (shiftRight),
    .arith (shiftArith),
    .y     (shiftY)
  );

  clmulUnit clmulUnit_i (
    .a    (a),
    .b    (b),
    .low  (clLow),
    .high (clHigh),
    .rev  (clRev)
  );

  // Result select
  always_comb begin
    case (op)
      ADD, SUB:      result = sum;
      SLL, SRL, SRA: result = shiftY;
      SLT:           result = {{(XLEN-1){1'b0}}, lt};
      SLTU:          result = {{(XLEN-1){1'b0}}, ltu};
      XOR, BINV:     result = a ^ condB;     // condB is the mask for binv
      OR, BSET:      result = a | condB;
      AND, BCLR:     result = a & condInvB;  // a & ~mask for bclr
      BEXT:          result = {{(XLEN-1){1'b0}}, |(a & condB)};
      CLMUL:         result = clLow;
      CLMULH:        result = clHigh;
      CLMULR:        result = clRev;
      default:       result = '0;            // Unused encodings
    endcase
  end

endmodule

// ==== hw/executeStage.sv ====
// Execute stage with a fixed one-cycle latency
// No back-pressure; every accepted request yields one response
// Ops from a disabled extension return zero with illegal set
// resp only updates on a valid request and is zero after reset

`timescale 1ns/1ps

module executeStage import execPkg::*; (
  input  logic     clk,
  input  logic     rst,        // Sync, active high
  input  logic     reqValid,   // Request strobe
  input  execReqT  req,
  input  featureT  features,   // Extension enables
  output logic     respValid,  // One cycle after reqValid
  output execRespT resp
);

  logic [XLEN-1:0] aluResult;
  logic            zbsOp;    // Op belongs to Zbs
  logic            zbcOp;    // Op belongs to Zbc
  logic            illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Legality
  ////////////////////////////////////////////////////////////////////////////

  assign zbsOp = req.op inside {BSET, BCLR, BINV, BEXT};
  assign zbcOp = req.op inside {CLMUL, CLMULH, CLMULR};

  // Base RV32I ops are always legal
  assign illegal = (zbsOp & ~features.zbsEn) | (zbcOp & ~features.zbcEn);

  // Datapath
  alu alu_i (
    .op     (req.op),
    .a      (req.a),
    .b      (req.b),
    .result (aluResult),
    .sum    ()           // Adder tap not needed here
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      respValid <= 1'b0;
      resp      <= '0;
    end else begin
      respValid <= reqValid;  // Strobe delayed by one
      if (reqValid) begin
        resp.result  <= illegal ? '0 : aluResult;  // Squash disabled ops
        resp.illegal <= illegal;
        resp.tag     <= req.tag;
      end
    end
  end

endmodule

// ==== hw/executeTop.sv ====
// Top level of the execute block
// Feature register writes take effect for the following request
// Responses come one cycle after requests, with no stall input

`timescale 1ns/1ps

module executeTop import execPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     reqValid,
  input  execReqT  req,
  input  logic     cfgWe,      // Feature write strobe
  input  featureT  cfgData,
  output logic     respValid,
  output execRespT resp
);

  featureT features;  // Enables into the stage

  featureRegs featureRegs_i (
    .clk      (clk),
    .rst      (rst),
    .cfgWe    (cfgWe),
    .cfgData  (cfgData),
    .features (features)
  );

  executeStage executeStage_i (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .features  (features),
    .respValid (respValid),
    .resp      (resp)
  );

endmodule

// ==== verif/execute_checker.sv ====
// Assertions on the execute stage, bound into every executeStage
// Latency is a fixed single cycle with no stall
// Reset is synchronous, so checks run from the edge after rst

`timescale 1ns/1ps

module execute_checker import execPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     reqValid,
  input logic     respValid,
  input execRespT resp
);

  int errCount = 0;  // Failed assertions so far

  // Strobe follows the request by exactly one edge
  assert property (@(posedge clk) disable iff (rst) reqValid |=> respValid)
    else begin
      $error("respValid missing one cycle after reqValid");
      errCount++;
    end
  assert property (@(posedge clk) disable iff (rst) !reqValid |=> !respValid)
    else begin
      $error("respValid raised without a request");
      errCount++;
    end

  // Squashed ops carry no data
  assert property (@(posedge clk) disable iff (rst)
                   (respValid && resp.illegal) |-> (resp.result == '0))
    else begin
      $error("Illegal response with a nonzero result");
      errCount++;
    end

  // Quiet after reset
  assert property (@(posedge clk) rst |=> (!respValid && resp == '0))
    else begin
      $error("Response not cleared by reset");
      errCount++;
    end

endmodule

bind executeStage execute_checker checker_i (
  .clk       (clk),
  .rst       (rst),
  .reqValid  (reqValid),
  .respValid (respValid),
  .resp      (resp)
);

// ==== verif/executeTb.sv ====
// Testbench for the execute block, random stimulus from an LCG
// Inputs change 2 ns after the rising edge; responses are checked at the falling edge
// The model keeps its own copy of the feature enables, updated on its own cfg writes
// Feature writes and resets happen only with no request in flight

`timescale 1ns/1ps

module executeTb import execPkg::*; ();

  localparam int      RESET_CYCLES = 3;
  localparam int      NUM_OPS      = 17;
  localparam int      NUM_RANDOM   = 2000;
  localparam int      MAX_GAP      = 3;     // Idle cycles between random requests
  localparam int      NUM_ZBS      = 300;
  localparam int      NUM_ZBC      = 300;
  localparam logic [31:0] SEED     = 32'hf900_6ef0;
  // Directed, feature sweeps and resets, counted generously
  localparam int      FIXED_CYCLES = 64 + 5 * (NUM_OPS + 4) + 4 * RESET_CYCLES;
  localparam int      WATCHDOG_CYCLES = FIXED_CYCLES + NUM_RANDOM * (MAX_GAP + 1)
                                      + NUM_ZBS + NUM_ZBC + 1000;

  logic     clk;
  logic     rst;
  logic     reqValid;
  execReqT  req;
  logic     cfgWe;
  featureT  cfgData;
  logic     respValid;
  execRespT resp;

  logic [31:0] lcgState;
  logic [3:0]  tagCnt;
  logic        modelZbs;  // Model copy of the enables
  logic        modelZbc;
  execRespT    expQ [$];  // Expected responses, oldest first
  aluOpE       opQ [$];   // Op of each, for error lines

  executeTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .cfgWe     (cfgWe),
    .cfgData   (cfgData),
    .respValid (respValid),
    .resp      (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Corner values now and then, else a plain random word
  function automatic logic [XLEN-1:0] pickOperand();
    logic [31:0] r;
    r = nextRand();
    case (r[3:0])
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'hffff_ffff;
      4'd2:    return 32'h8000_0000;
      4'd3:    return 32'h7fff_ffff;
      default: return nextRand();
    endcase
  endfunction

  function automatic aluOpE randomOp(int first, int count);
    logic [4:0] code;
    code = first + (nextRand() % count);
    return aluOpE'(code);
  endfunction

  function automatic logic [XLEN-1:0] modelResult(aluOpE op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic [63:0]            prod;
    int                     sh;
    sa   = a;
    sh   = b[4:0];
    prod = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (b[i]) prod = prod ^ ({32'b0, a} << i);  // Carry-less partial product
    end
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return sa >>> sh;
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      XOR:     return a ^ b;
      OR:      return a | b;
      AND:     return a & b;
      BSET:    return a | (32'd1 << sh);
      BCLR:    return a & ~(32'd1 << sh);
      BINV:    return a ^ (32'd1 << sh);
      BEXT:    return {31'b0, a[sh]};
      CLMUL:   return prod[31:0];
      CLMULH:  return prod[63:32];
      CLMULR:  return prod[62:31];
      default: return '0;
    endcase
  endfunction

  function automatic execRespT predictResp(execReqT r);
    execRespT e;
    logic     bad;
    bad = ((r.op inside {BSET, BCLR, BINV, BEXT}) && !modelZbs)
       || ((r.op inside {CLMUL, CLMULH, CLMULR}) && !modelZbc);
    e.result  = bad ? '0 : modelResult(r.op, r.a, r.b);
    e.illegal = bad;
    e.tag     = r.tag;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive steps, one clock each
  ////////////////////////////////////////////////////////////////////////////

  task automatic issueReq(aluOpE op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    @(posedge clk);
    #2;
    req.op   = op;
    req.a    = a;
    req.b    = b;
    req.tag  = tagCnt;
    reqValid = 1'b1;
    cfgWe    = 1'b0;
    tagCnt   = tagCnt + 4'd1;
    expQ.push_back(predictResp(req));
    opQ.push_back(op);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #2;
    reqValid = 1'b0;
    cfgWe    = 1'b0;
  endtask

  task automatic writeFeatures(logic zbs, logic zbc);
    @(posedge clk);
    #2;
    reqValid      = 1'b0;
    cfgWe         = 1'b1;
    cfgData.zbsEn = zbs;
    cfgData.zbcEn = zbc;
    modelZbs      = zbs;  // Next request already sees it
    modelZbc      = zbc;
  endtask

  task automatic drainResponses();
    while (expQ.size() != 0) idleCycle();
    idleCycle();
  endtask

  // Every opcode back to back on the same operands
  task automatic sweepOps(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    for (int i = 0; i < NUM_OPS; i++) issueReq(aluOpE'(i[4:0]), a, b);
  endtask

  task automatic applyReset();
    @(posedge clk);
    #2;
    rst      = 1'b1;
    reqValid = 1'b0;
    cfgWe    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst      = 1'b0;
    modelZbs = 1'b1;  // Enables come back on
    modelZbc = 1'b1;
  endtask

  task automatic checkQuietOutputs();
    assert (respValid === 1'b0 && resp === '0) else begin
      $display("FAIL @%0t: after reset respValid %b resp %h, expected 0 and 0",
               $time, respValid, resp);
      $display("TEST FAIL");
      $fatal(1, "Outputs not quiet after reset");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response monitor, samples at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin : respMonitor
    logic     expectValid;  // reqValid seen one edge earlier
    execRespT expResp;
    aluOpE    expOp;
    expectValid = 1'b0;
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    forever begin
      @(negedge clk);
      assert (respValid === expectValid) else begin
        $display("FAIL @%0t: respValid is %b, expected %b", $time, respValid, expectValid);
        $display("TEST FAIL");
        $fatal(1, "Response strobe timing wrong");
      end
      if (expectValid) begin
        expResp = expQ.pop_front();
        expOp   = opQ.pop_front();
        assert (resp === expResp) else begin
          $display("FAIL @%0t: %s tag %0d got result %h illegal %b tag %0d, expected %h %b",
                   $time, expOp.name(), expResp.tag, resp.result, resp.illegal, resp.tag,
                   expResp.result, expResp.illegal);
          $display("TEST FAIL");
          $fatal(1, "Response mismatch");
        end
      end
      expectValid = reqValid;
    end
  end

  // Bound assertions in the stage
  initial begin : checkerWatch
    wait (dut_i.executeStage_i.checker_i.errCount != 0);
    $display("Error: a bound assertion on the execute stage failed at %0t", $time);
    $display("TEST FAIL");
    $fatal(1, "Bound assertion failed");
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    rst      = 1'b1;
    reqValid = 1'b0;
    req      = '0;
    cfgWe    = 1'b0;
    cfgData  = '0;
    lcgState = SEED;
    tagCnt   = '0;
    modelZbs = 1'b1;
    modelZbc = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    repeat (2) begin
      idleCycle();
      checkQuietOutputs();
    end

    // Directed RV32I corners
    issueReq(SLT,  32'h8000_0000, 32'h0000_0001);  // Negative below positive
    issueReq(SLTU, 32'h8000_0000, 32'h0000_0001);
    issueReq(SLT,  32'h0000_0001, 32'h8000_0000);
    issueReq(SLTU, 32'h0000_0001, 32'h8000_0000);
    issueReq(SLT,  32'h8000_0000, 32'h8000_0000);
    issueReq(SUB,  32'h0000_0000, 32'h0000_0001);  // Wraps to all ones
    issueReq(SUB,  32'h8000_0000, 32'h0000_0001);
    issueReq(ADD,  32'hffff_ffff, 32'h0000_0001);
    issueReq(SRA,  32'h8000_0000, 32'd31);
    issueReq(SRA,  32'hf000_0000, 32'd4);
    issueReq(SRA,  32'hffff_fff0, 32'd0);
    issueReq(SLL,  32'h1234_5678, 32'd0);
    issueReq(SLL,  32'h0000_0001, 32'd31);
    issueReq(SRL,  32'h8000_0000, 32'd31);
    issueReq(SRL,  32'hdead_beef, 32'hffff_ffe0);  // Only b[4:0] counts
    drainResponses();

    // Random ops, random gaps
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = nextRand();
      if (r[3:2] == 2'd0) begin
        repeat (r[5:4]) idleCycle();
      end
      issueReq(randomOp(0, NUM_OPS), pickOperand(), pickOperand());
    end
    drainResponses();

    // Zbs with random indices, bext at both ends
    for (int n = 0; n < NUM_ZBS; n++) issueReq(randomOp(BSET, 4), nextRand(), nextRand());
    issueReq(BEXT, 32'h0000_0001, 32'd0);
    issueReq(BEXT, 32'h8000_0000, 32'd31);
    issueReq(BEXT, 32'h7fff_ffff, 32'd31);
    issueReq(BEXT, 32'hffff_fffe, 32'd32);
    drainResponses();

    // Carry-less windows
    for (int n = 0; n < NUM_ZBC; n++) issueReq(randomOp(CLMUL, 3), nextRand(), nextRand());
    for (int i = 0; i < 3; i++) begin
      issueReq(aluOpE'(CLMUL + i), 32'hffff_ffff, 32'hffff_ffff);
      issueReq(aluOpE'(CLMUL + i), 32'hffff_ffff, 32'h0000_0001);
    end
    drainResponses();

    // Feature enables
    writeFeatures(1'b0, 1'b1);
    sweepOps(32'h8765_4321, 32'h0000_0013);
    writeFeatures(1'b1, 1'b0);
    sweepOps(32'h8765_4321, 32'h0000_0013);
    writeFeatures(1'b0, 1'b0);
    sweepOps(32'hffff_ffff, 32'hffff_ffff);
    writeFeatures(1'b1, 1'b1);  // Back on for the next request
    sweepOps(32'h8765_4321, 32'h0000_0013);
    drainResponses();

    // Reset again with both groups off
    writeFeatures(1'b0, 1'b0);
    applyReset();
    repeat (2) begin
      idleCycle();
      checkQuietOutputs();
    end
    issueReq(BSET, 32'h0000_0000, 32'd7);
    issueReq(CLMUL, 32'h0000_0003, 32'h0000_0003);
    drainResponses();

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
hw/execPkg.sv
hw/featureRegs.sv
hw/shifter.sv
hw/clmulUnit.sv
hw/alu.sv
hw/executeStage.sv
hw/executeTop.sv
verif/execute_checker.sv
verif/executeTb.sv

// ==== Bender.yml ====
package:
  name: execute_stage

sources:
  - hw/execPkg.sv
  - hw/featureRegs.sv
  - hw/shifter.sv
  - hw/clmulUnit.sv
  - hw/alu.sv
  - hw/executeStage.sv
  - hw/executeTop.sv
  - target: test
    files:
      - verif/execute_checker.sv
      - verif/executeTb.sv
